// ==== testbench/rename_stimulus.txt ====
# test | lane0 req rd rs1 rs2 | lane1 same | wb0 valid arn rrn result | wb1 same | srcs a b
# then expected: ok rd_phys tag1 tag2 per lane | data_a valid_a data_b valid_b | free_count
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 3f 0 0 0 0 0 0 0 0 0 1 0 1 20
1 1 1 2 3 1 2 1 4 0 0 0 0 0 0 0 0 20 1 1 20 2 3 1 21 20 4 0 0 0 1 1e
2 1 3 1 2 1 0 3 1 0 0 0 0 0 0 0 0 22 3 1 22 20 21 1 0 22 20 0 0 0 1 1d
2 1 1 1 5 1 1 1 3 0 0 0 0 0 0 0 0 23 24 1 23 20 5 1 24 23 22 0 0 0 0 1b
2 1 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 1 2 1 0 24 21 0 0 0 0 0 1 0 1 1b
3 0 0 0 0 0 0 0 0 1 0 20 1111 1 0 21 2222 20 21 0 0 0 0 0 0 0 0 1111 1 2222 1 1b
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 22 23 0 0 0 0 0 0 0 0 0 0 0 0 1b
3 0 0 0 0 0 0 0 0 1 0 24 abcd 0 0 0 0 24 20 0 0 0 0 0 0 0 0 abcd 1 1111 1 1b
4 0 0 0 0 0 0 0 0 1 2 21 2222 1 1 20 1111 2 1 0 0 0 0 0 0 0 0 2222 1 1111 1 1d
4 1 0 2 1 0 0 0 0 0 0 0 0 0 0 0 0 21 20 1 0 2 24 0 0 0 0 0 0 0 0 1d
4 1 3 3 0 0 0 0 0 1 3 22 3333 0 0 0 0 3 25 1 25 22 0 0 0 0 0 3333 1 0 0 1d
4 1 0 3 2 0 0 0 0 0 0 0 0 0 0 0 0 3 2 1 0 25 2 0 0 0 0 3333 1 2222 1 1d
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 26 0 0 1 27 0 0 0 1 0 1 1b
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 28 0 0 1 29 0 0 0 1 0 1 19
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 2a 0 0 1 2b 0 0 0 1 0 1 17
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 2c 0 0 1 2d 0 0 0 1 0 1 15
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 2e 0 0 1 2f 0 0 0 1 0 1 13
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 30 0 0 1 31 0 0 0 1 0 1 11
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 32 0 0 1 33 0 0 0 1 0 1 f
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 34 0 0 1 35 0 0 0 1 0 1 d
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 36 0 0 1 37 0 0 0 1 0 1 b
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 38 0 0 1 39 0 0 0 1 0 1 9
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 3a 0 0 1 3b 0 0 0 1 0 1 7
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 3c 0 0 1 3d 0 0 0 1 0 1 5
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 3e 0 0 1 3f 0 0 0 1 0 1 3
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 21 0 0 1 20 0 0 0 1 0 1 1
5 1 4 0 0 1 5 0 0 0 0 0 0 0 0 0 0 4 5 1 22 0 0 0 0 0 0 0 1 0 1 0
5 1 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 5 0 0 0 0 0 0 0 0 0 1 0 1 0
5 1 6 0 0 0 0 0 0 1 4 22 4444 0 0 0 0 4 22 0 0 0 0 0 0 0 0 4444 1 0 0 1
5 1 6 0 0 1 7 0 0 0 0 0 0 0 0 0 0 4 22 1 22 0 0 0 0 0 0 4444 1 0 0 0

// ==== tb.f ====
src/rename_pkg.sv
src/rename_if.sv
src/free_list.sv
src/rename_lane.sv
src/map_table.sv
src/rename_unit.sv
testbench/tb_rename.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the rename unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module tb_rename -o sim_rename
./obj_dir/sim_rename > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
exit 0

// ==== testbench/tb_rename.sv ====
`timescale 1ns/1ps

module tb_rename;

  localparam int max_rows = 64;
  localparam int fields   = 32;  // Columns per stimulus line.

  logic                    global_bus;
  logic                    rst_n;
  logic                    rename_req [rename_pkg::lanes];
  rename_pkg::reg_idx_t    rd [rename_pkg::lanes];
  rename_pkg::reg_idx_t    rs_1 [rename_pkg::lanes];
  rename_pkg::reg_idx_t    rs_2 [rename_pkg::lanes];
  logic                    rename_done [rename_pkg::lanes];
  logic                    rename_ok [rename_pkg::lanes];
  rename_pkg::reg_idx_t    rd_phys [rename_pkg::lanes];
  rename_pkg::reg_idx_t    rs_1_tag [rename_pkg::lanes];
  rename_pkg::reg_idx_t    rs_2_tag [rename_pkg::lanes];
  logic                    wb_valid [rename_pkg::lanes];
  rename_pkg::reg_idx_t    wb_arn [rename_pkg::lanes];
  rename_pkg::reg_idx_t    wb_rrn [rename_pkg::lanes];
  rename_pkg::data_t       wb_result [rename_pkg::lanes];
  rename_pkg::reg_idx_t    rd_src_1 [rename_pkg::lanes];
  rename_pkg::reg_idx_t    rd_src_2 [rename_pkg::lanes];
  rename_pkg::data_t       rd_data_1 [rename_pkg::lanes];
  rename_pkg::data_t       rd_data_2 [rename_pkg::lanes];
  logic                    rd_valid_1 [rename_pkg::lanes];
  logic                    rd_valid_2 [rename_pkg::lanes];
  rename_pkg::free_count_t free_count;

  logic [31:0] rows [max_rows][fields];
  int n_rows = 0;
  int load_ok = 1;
  int checks = 0;
  int errors = 0;
  int test_errors = 0;
  int cur_test = 0;
  int cycles = 0;
  int cycle_limit = 0;

  rename_unit dut0 (
    .global_bus  (global_bus),
    .rst_n       (rst_n),
    .rename_req  (rename_req),
    .rd          (rd),
    .rs_1        (rs_1),
    .rs_2        (rs_2),
    .rename_done (rename_done),
    .rename_ok   (rename_ok),
    .rd_phys     (rd_phys),
    .rs_1_tag    (rs_1_tag),
    .rs_2_tag    (rs_2_tag),
    .wb_valid    (wb_valid),
    .wb_arn      (wb_arn),
    .wb_rrn      (wb_rrn),
    .wb_result   (wb_result),
    .rd_src_1    (rd_src_1),
    .rd_src_2    (rd_src_2),
    .rd_data_1   (rd_data_1),
    .rd_data_2   (rd_data_2),
    .rd_valid_1  (rd_valid_1),
    .rd_valid_2  (rd_valid_2),
    .free_count  (free_count)
  );

  initial begin
    global_bus = 1'b0;
    forever #2 global_bus = ~global_bus;
  end

  always @(posedge global_bus) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic clear_inputs();
    for (int l = 0; l < rename_pkg::lanes; l++) begin
      rename_req[l] = 1'b0;
      rd[l]         = '0;
      rs_1[l]       = '0;
      rs_2[l]       = '0;
      wb_valid[l]   = 1'b0;
      wb_arn[l]     = '0;
      wb_rrn[l]     = '0;
      wb_result[l]  = '0;
      rd_src_1[l]   = '0;
      rd_src_2[l]   = '0;
    end
  endtask

  task automatic load_stimulus();
    int fd;
    int code;
    int cnt;
    int line_no;
    string line;
    logic [31:0] f [fields];
    line_no = 0;
    fd = $fopen("testbench/rename_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/rename_stimulus.txt");
      load_ok = 0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        line_no++;
        if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        cnt = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                      f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15],
                      f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
                      f[24], f[25], f[26], f[27], f[28], f[29], f[30], f[31]);
        if (cnt != fields) begin
          $display("Stimulus line %0d is malformed: found %0d of %0d fields",
                   line_no, cnt, fields);
          load_ok = 0;
        end else if (n_rows >= max_rows) begin
          $display("Stimulus file has more than %0d lines", max_rows);
          load_ok = 0;
        end else begin
          for (int k = 0; k < fields; k++) begin
            rows[n_rows][k] = f[k];
          end
          n_rows++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Port 1 reads the same two indices as port 0, swapped.
  task automatic drive_row(input int r);
    for (int l = 0; l < rename_pkg::lanes; l++) begin
      rename_req[l] = rows[r][1 + 4*l][0];
      rd[l]         = rename_pkg::reg_idx_t'(rows[r][2 + 4*l]);
      rs_1[l]       = rename_pkg::reg_idx_t'(rows[r][3 + 4*l]);
      rs_2[l]       = rename_pkg::reg_idx_t'(rows[r][4 + 4*l]);
      wb_valid[l]   = rows[r][9 + 4*l][0];
      wb_arn[l]     = rename_pkg::reg_idx_t'(rows[r][10 + 4*l]);
      wb_rrn[l]     = rename_pkg::reg_idx_t'(rows[r][11 + 4*l]);
      wb_result[l]  = rows[r][12 + 4*l];
    end
    rd_src_1[0] = rename_pkg::reg_idx_t'(rows[r][17]);
    rd_src_2[0] = rename_pkg::reg_idx_t'(rows[r][18]);
    rd_src_1[1] = rename_pkg::reg_idx_t'(rows[r][18]);
    rd_src_2[1] = rename_pkg::reg_idx_t'(rows[r][17]);
  endtask

  task automatic check_row(input int r);
    for (int l = 0; l < rename_pkg::lanes; l++) begin
      // Done pulses once for every request of the previous edge.
      check_val($sformatf("rename_done[%0d]", l), 32'(rows[r][1 + 4*l][0]),
                32'(rename_done[l]));
      if (rows[r][1 + 4*l][0]) begin
        check_val($sformatf("rename_ok[%0d]", l), rows[r][19 + 4*l], 32'(rename_ok[l]));
        check_val($sformatf("rd_phys[%0d]", l), rows[r][20 + 4*l], 32'(rd_phys[l]));
        check_val($sformatf("rs_1_tag[%0d]", l), rows[r][21 + 4*l], 32'(rs_1_tag[l]));
        check_val($sformatf("rs_2_tag[%0d]", l), rows[r][22 + 4*l], 32'(rs_2_tag[l]));
      end
    end
    check_val("rd_data_1[0]", rows[r][27], rd_data_1[0]);
    check_val("rd_valid_1[0]", rows[r][28], 32'(rd_valid_1[0]));
    check_val("rd_data_2[0]", rows[r][29], rd_data_2[0]);
    check_val("rd_valid_2[0]", rows[r][30], 32'(rd_valid_2[0]));
    check_val("rd_data_1[1]", rows[r][29], rd_data_1[1]);
    check_val("rd_valid_1[1]", rows[r][30], 32'(rd_valid_1[1]));
    check_val("rd_data_2[1]", rows[r][27], rd_data_2[1]);
    check_val("rd_valid_2[1]", rows[r][28], 32'(rd_valid_2[1]));
    check_val("free_count", rows[r][31], 32'(free_count));
  endtask

  task automatic report_test(input int t);
    $display("Test %0d: %s, %0d errors", t, (test_errors == 0) ? "ok" : "FAILED", test_errors);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    clear_inputs();
    rst_n = 1'b0;
    load_stimulus();
    if (load_ok == 0 || n_rows == 0) begin
      $display("No usable stimulus, run stopped");
      $display("Some tests failed");
      $finish;
    end else begin
      cycle_limit = 2 * n_rows + 20;
      repeat (2) @(posedge global_bus);
      @(negedge global_bus);
      rst_n = 1'b1;
      cur_test = int'(rows[0][0]);
      for (int r = 0; r < n_rows; r++) begin
        if (r > 0) begin
          @(negedge global_bus);
        end
        if (int'(rows[r][0]) != cur_test) begin
          report_test(cur_test);
          cur_test = int'(rows[r][0]);
          test_errors = 0;
        end
        drive_row(r);
        @(posedge global_bus);
        #1;  // Outputs of this edge have settled.
        check_row(r);
      end
      report_test(cur_test);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

// ==== src/rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
  input  logic                    global_bus,
  input  logic                    rst_n,
  // Rename, one entry per lane.
  input  logic                    rename_req [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t    rd [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t    rs_1 [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t    rs_2 [rename_pkg::lanes],
  output logic                    rename_done [rename_pkg::lanes],
  output logic                    rename_ok [rename_pkg::lanes],
  output rename_pkg::reg_idx_t    rd_phys [rename_pkg::lanes],
  output rename_pkg::reg_idx_t    rs_1_tag [rename_pkg::lanes],
  output rename_pkg::reg_idx_t    rs_2_tag [rename_pkg::lanes],
  // Writeback and commit.
  input  logic                    wb_valid [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t    wb_arn [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t    wb_rrn [rename_pkg::lanes],
  input  rename_pkg::data_t       wb_result [rename_pkg::lanes],
  // Read ports.
  input  rename_pkg::reg_idx_t    rd_src_1 [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t    rd_src_2 [rename_pkg::lanes],
  output rename_pkg::data_t       rd_data_1 [rename_pkg::lanes],
  output rename_pkg::data_t       rd_data_2 [rename_pkg::lanes],
  output logic                    rd_valid_1 [rename_pkg::lanes],
  output logic                    rd_valid_2 [rename_pkg::lanes],
  output rename_pkg::free_count_t free_count
);

  logic                 grant [rename_pkg::lanes];
  rename_pkg::reg_idx_t grant_phys [rename_pkg::lanes];
  logic                 take [rename_pkg::lanes];
  logic                 release_en [rename_pkg::lanes];
  rename_pkg::reg_idx_t release_phys [rename_pkg::lanes];

  rename_if lane_bus [rename_pkg::lanes] ();

  free_list u_free_list (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .grant        (grant),
    .grant_phys   (grant_phys),
    .take         (take),
    .release_en   (release_en),
    .release_phys (release_phys),
    .free_count   (free_count)
  );

  for (genvar i = 0; i < rename_pkg::lanes; i++) begin : gen_lane
    rename_lane u_lane (
      .global_bus  (global_bus),
      .rst_n       (rst_n),
      .rename_req  (rename_req[i]),
      .rd          (rd[i]),
      .rs_1        (rs_1[i]),
      .rs_2        (rs_2[i]),
      .grant       (grant[i]),
      .grant_phys  (grant_phys[i]),
      .take        (take[i]),
      .tbl         (lane_bus[i]),
      .rename_done (rename_done[i]),
      .rename_ok   (rename_ok[i]),
      .rd_phys     (rd_phys[i]),
      .rs_1_tag    (rs_1_tag[i]),
      .rs_2_tag    (rs_2_tag[i])
    );
  end

  map_table u_map_table (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .lane         (lane_bus),
    .wb_valid     (wb_valid),
    .wb_arn       (wb_arn),
    .wb_rrn       (wb_rrn),
    .wb_result    (wb_result),
    .release_en   (release_en),
    .release_phys (release_phys),
    .rd_src_1     (rd_src_1),
    .rd_src_2     (rd_src_2),
    .rd_data_1    (rd_data_1),
    .rd_data_2    (rd_data_2),
    .rd_valid_1   (rd_valid_1),
    .rd_valid_2   (rd_valid_2)
  );

endmodule

// ==== src/map_table.sv ====
`timescale 1ns/1ps

module map_table (
  input  logic                 global_bus,
  input  logic                 rst_n,
  rename_if.tbl                lane [rename_pkg::lanes],
  input  logic                 wb_valid [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t wb_arn [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t wb_rrn [rename_pkg::lanes],
  input  rename_pkg::data_t    wb_result [rename_pkg::lanes],
  output logic                 release_en [rename_pkg::lanes],
  output rename_pkg::reg_idx_t release_phys [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t rd_src_1 [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t rd_src_2 [rename_pkg::lanes],
  output rename_pkg::data_t    rd_data_1 [rename_pkg::lanes],
  output rename_pkg::data_t    rd_data_2 [rename_pkg::lanes],
  output logic                 rd_valid_1 [rename_pkg::lanes],
  output logic                 rd_valid_2 [rename_pkg::lanes]
);

  rename_pkg::reg_entry_t regs [rename_pkg::reg_count];

  // Lane bundles flattened into arrays so loops can walk them.
  logic                 alloc [rename_pkg::lanes];
  rename_pkg::reg_idx_t rd [rename_pkg::lanes];
  rename_pkg::reg_idx_t rs_1 [rename_pkg::lanes];
  rename_pkg::reg_idx_t rs_2 [rename_pkg::lanes];
  rename_pkg::reg_idx_t new_phys [rename_pkg::lanes];
  rename_pkg::reg_idx_t tag_1 [rename_pkg::lanes];
  rename_pkg::reg_idx_t tag_2 [rename_pkg::lanes];
  logic                 commit [rename_pkg::lanes];

  for (genvar i = 0; i < rename_pkg::lanes; i++) begin : gen_port
    assign alloc[i]         = lane[i].alloc;
    assign rd[i]            = lane[i].rd;
    assign rs_1[i]          = lane[i].rs_1;
    assign rs_2[i]          = lane[i].rs_2;
    assign new_phys[i]      = lane[i].new_phys;
    assign lane[i].rs_1_tag = tag_1[i];
    assign lane[i].rs_2_tag = tag_2[i];

    // A nonzero arn marks a commit.
    assign commit[i]       = wb_valid[i] && (wb_arn[i] != '0);
    assign release_en[i]   = commit[i];
    assign release_phys[i] = wb_rrn[i];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Source resolution
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int l = 0; l < rename_pkg::lanes; l++) begin
      tag_1[l] = (regs[rs_1[l]].rrn != '0) ? regs[rs_1[l]].rrn : rs_1[l];
      tag_2[l] = (regs[rs_2[l]].rrn != '0) ? regs[rs_2[l]].rrn : rs_2[l];
      // Older lanes in the same group rename first, the newest one wins.
      for (int k = 0; k < l; k++) begin
        if (alloc[k] && (rs_1[l] == rd[k])) begin
          tag_1[l] = new_phys[k];
        end
        if (alloc[k] && (rs_2[l] == rd[k])) begin
          tag_2[l] = new_phys[k];
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage updates
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int j = 0; j < rename_pkg::reg_count; j++) begin
        regs[j] <= '{value: '0, valid: 1'b1, rrn: '0};
      end
    end else begin
      for (int p = 0; p < rename_pkg::lanes; p++) begin
        if (wb_valid[p] && !commit[p]) begin
          // Execution result into its physical register.
          regs[wb_rrn[p]].value <= wb_result[p];
          regs[wb_rrn[p]].valid <= 1'b1;
        end else if (commit[p]) begin
          regs[wb_arn[p]].value <= wb_result[p];
          regs[wb_arn[p]].valid <= 1'b1;
          // Keep a newer mapping.
          if (regs[wb_arn[p]].rrn == wb_rrn[p]) begin
            regs[wb_arn[p]].rrn <= '0;
          end
          regs[wb_rrn[p]] <= '0;  // Empty, back to the free queue.
        end
      end

      // Renames come last so they override a same-edge mapping clear.
      for (int l = 0; l < rename_pkg::lanes; l++) begin
        if (alloc[l]) begin
          regs[rd[l]].rrn         <= new_phys[l];
          regs[new_phys[l]].valid <= 1'b0;
        end
      end
    end
  end

  // Read ports.
  always_comb begin
    for (int p = 0; p < rename_pkg::lanes; p++) begin
      rd_data_1[p]  = regs[rd_src_1[p]].value;
      rd_valid_1[p] = regs[rd_src_1[p]].valid;
      rd_data_2[p]  = regs[rd_src_2[p]].value;
      rd_valid_2[p] = regs[rd_src_2[p]].valid;
    end
  end

endmodule

// ==== src/rename_lane.sv ====
`timescale 1ns/1ps

module rename_lane (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  logic                 rename_req,
  input  rename_pkg::reg_idx_t rd,
  input  rename_pkg::reg_idx_t rs_1,
  input  rename_pkg::reg_idx_t rs_2,
  input  logic                 grant,
  input  rename_pkg::reg_idx_t grant_phys,
  output logic                 take,
  rename_if.lane               tbl,
  output logic                 rename_done,
  output logic                 rename_ok,
  output rename_pkg::reg_idx_t rd_phys,
  output rename_pkg::reg_idx_t rs_1_tag,
  output rename_pkg::reg_idx_t rs_2_tag
);

  logic need_reg;
  logic alloc;
  logic admit;

  // Register 0 is never renamed.
  assign need_reg = (rd != '0);
  assign alloc    = rename_req && need_reg && grant;
  // Refused only when a register is needed and none is left.
  assign admit    = rename_req && (!need_reg || grant);

  assign take         = alloc;
  assign tbl.alloc    = alloc;
  assign tbl.rd       = rd;
  assign tbl.rs_1     = rs_1;
  assign tbl.rs_2     = rs_2;
  assign tbl.new_phys = grant_phys;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      rename_done <= 1'b0;
      rename_ok   <= 1'b0;
    end else begin
      rename_done <= rename_req;  // One cycle per request.
      rename_ok   <= admit;
    end
  end

  // Tags come from the mapping as it stood before this edge.
  always_ff @(posedge global_bus) begin
    if (rename_req) begin
      rd_phys  <= alloc ? grant_phys : '0;
      rs_1_tag <= tbl.rs_1_tag;
      rs_2_tag <= tbl.rs_2_tag;
    end
  end

endmodule

// ==== src/free_list.sv ====
`timescale 1ns/1ps

module free_list (
  input  logic                    global_bus,
  input  logic                    rst_n,
  output logic                    grant [rename_pkg::lanes],
  output rename_pkg::reg_idx_t    grant_phys [rename_pkg::lanes],
  input  logic                    take [rename_pkg::lanes],
  input  logic                    release_en [rename_pkg::lanes],
  input  rename_pkg::reg_idx_t    release_phys [rename_pkg::lanes],
  output rename_pkg::free_count_t free_count
);

  rename_pkg::reg_idx_t slots [rename_pkg::phys_regs];
  logic [4:0] rd_ptr;
  logic [4:0] wr_ptr;
  logic [1:0] pops;
  logic [1:0] pushes;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grants
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    grant[0]      = (free_count != '0);
    grant_phys[0] = slots[rd_ptr];
    // Lane 1 gets the head when lane 0 leaves it.
    if (take[0]) begin
      grant[1]      = (free_count >= rename_pkg::free_count_t'(2));
      grant_phys[1] = slots[rd_ptr + 5'd1];
    end else begin
      grant[1]      = (free_count != '0);
      grant_phys[1] = slots[rd_ptr];
    end
  end

  always_comb begin
    pops   = 2'(take[0]) + 2'(take[1]);
    pushes = 2'(release_en[0]) + 2'(release_en[1]);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Queue state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;  // Full queue, so write pointer meets read pointer.
      free_count <= rename_pkg::free_count_t'(rename_pkg::phys_regs);
      for (int j = 0; j < rename_pkg::phys_regs; j++) begin
        slots[j] <= rename_pkg::reg_idx_t'(rename_pkg::arch_regs + j);
      end
    end else begin
      rd_ptr     <= rd_ptr + 5'(pops);
      wr_ptr     <= wr_ptr + 5'(pushes);
      free_count <= free_count - rename_pkg::free_count_t'(pops)
                    + rename_pkg::free_count_t'(pushes);
      // Port 0 goes in ahead of port 1.
      if (release_en[0]) begin
        slots[wr_ptr] <= release_phys[0];
      end
      if (release_en[1]) begin
        slots[wr_ptr + 5'(release_en[0])] <= release_phys[1];
      end
    end
  end

endmodule

// ==== src/rename_if.sv ====
`timescale 1ns/1ps

// One rename lane talking to the map table.
interface rename_if;

  logic                alloc;     // Lane renames with a new register this cycle.
  rename_pkg::reg_idx_t rd;
  rename_pkg::reg_idx_t rs_1;
  rename_pkg::reg_idx_t rs_2;
  rename_pkg::reg_idx_t new_phys;  // Register handed to rd.

  // Resolved sources, combinational from the table.
  rename_pkg::reg_idx_t rs_1_tag;
  rename_pkg::reg_idx_t rs_2_tag;

  modport lane (
    output alloc,
    output rd,
    output rs_1,
    output rs_2,
    output new_phys,
    input  rs_1_tag,
    input  rs_2_tag
  );

  // Map table side.
  modport tbl (
    input  alloc,
    input  rd,
    input  rs_1,
    input  rs_2,
    input  new_phys,
    output rs_1_tag,
    output rs_2_tag
  );

endinterface

// ==== src/rename_pkg.sv ====
package rename_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int xlen      = 32;  // Data word width.
  localparam int arch_regs = 32;  // Entries 0 to 31.
  localparam int phys_regs = 32;  // Entries 32 to 63, the rename pool.
  localparam int reg_count = arch_regs + phys_regs;
  localparam int lanes     = 2;   // Rename lanes and result/read ports.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Index into the storage array.
  // Zero doubles as "not renamed" in the rrn field.
  typedef logic [5:0] reg_idx_t;

  typedef logic [xlen-1:0] data_t;

  // Free entries, 0 to 32.
  typedef logic [5:0] free_count_t;

  // One storage entry.
  // rrn is only meaningful in architectural entries, where it names the
  // physical register holding the newest in-flight value.
  typedef struct packed {
    data_t    value;
    logic     valid;
    reg_idx_t rrn;
  } reg_entry_t;

endpackage
